//--- pid_pkg.sv
`default_nettype none

package pid_pkg;

	////////////////////////////////////////////////////////////
	// channel and datapath widths
	////////////////////////////////////////////////////////////

	localparam int n_chan  = 2;   // adc channels, one dac channel each
	localparam int w_chan  = 1;   // channel tag
	localparam int w_adc   = 18;  // signed adc sample
	localparam int w_comp  = 64;  // pid / opp arithmetic
	localparam int w_coef  = 16;  // setpoint and p, i, d coefficients

	// oversample filter
	localparam int w_osm   = 3;
	localparam int osm_max = 6;                // at most 64 samples averaged
	localparam int w_acc   = w_adc + osm_max;  // sum of 2^osm_max samples fits here
	localparam int w_cnt   = osm_max + 1;      // counts up to 2^osm_max

	// output preprocessor
	localparam int w_mlt   = 10;  // unsigned gain
	localparam int w_rs    = 6;   // right shift after the gain

	////////////////////////////////////////////////////////////
	// dac8568 serial frame
	////////////////////////////////////////////////////////////

	localparam int w_dac   = 16;
	localparam int w_frame = 32;  // prefix, cmd, addr, code, feature
	localparam int w_addr  = 4;

	localparam logic [3:0] dac_cmd_write_update = 4'b0011;  // write and update channel

	// system clocks per sclk half period, sclk = clk50 / (2*sclk_div)
	localparam int sclk_div = 1;

	////////////////////////////////////////////////////////////
	// payload types
	////////////////////////////////////////////////////////////

	typedef logic signed [w_adc-1:0]  adc_word_t;
	typedef logic signed [w_comp-1:0] comp_word_t;
	typedef logic [w_chan-1:0]        chan_t;
	typedef logic [w_dac-1:0]         dac_code_t;  // straight binary dac code

endpackage

`default_nettype wire

//--- stage_if.sv
`timescale 1ns/100ps
`default_nettype none

// one tagged item between two pipeline stages
// valid is a single cycle strobe, nothing pushes back
interface stage_if #(
	parameter type payload_t = logic
) ();

	logic           valid;    // item strobe
	pid_pkg::chan_t chan;     // source adc channel
	payload_t       data;     // sample, pid sum or dac code
	logic           lock_en;  // lock state of that channel, rides along

	modport src (
		output valid,
		output chan,
		output data,
		output lock_en
	);

	modport dst (
		input valid,
		input chan,
		input data,
		input lock_en
	);

endinterface

`default_nettype wire

//--- dac_cmd_if.sv
`timescale 1ns/100ps
`default_nettype none

interface dac_cmd_if ();

	logic                 valid;  // one cycle, only while controller idle
	pid_pkg::chan_t       chan;   // dac address
	pid_pkg::dac_code_t   code;
	logic                 done;   // frame finished, controller idle again

	modport queue (
		output valid,
		output chan,
		output code,
		input  done
	);

	modport ctrl (
		input  valid,
		input  chan,
		input  code,
		output done
	);

endinterface

`default_nettype wire

//--- oversample_filter.sv
`timescale 1ns/100ps
`default_nettype none

module oversample_filter (
	input  logic                       clk50,
	input  logic                       reset,
	input  logic [pid_pkg::w_osm-1:0]  osm,           // average 2^osm samples
	input  logic [pid_pkg::n_chan-1:0] lock_en,
	input  logic                       sample_valid,
	input  pid_pkg::chan_t             sample_chan,
	input  pid_pkg::adc_word_t         sample_data,
	stage_if.src                       out
);

	logic signed [pid_pkg::w_acc-1:0] acc [pid_pkg::n_chan];  // running sum per channel
	logic [pid_pkg::w_cnt-1:0]        cnt [pid_pkg::n_chan];  // samples taken so far

	logic [pid_pkg::w_osm-1:0]        osm_eff;
	logic [pid_pkg::w_cnt-1:0]        target;
	logic [pid_pkg::w_cnt-1:0]        cnt_nxt;
	logic signed [pid_pkg::w_acc-1:0] sum;
	logic signed [pid_pkg::w_acc-1:0] avg;
	logic                             last;

	always_comb begin
		// modes above osm_max would overflow the counter
		osm_eff = (osm > pid_pkg::w_osm'(pid_pkg::osm_max)) ? pid_pkg::w_osm'(pid_pkg::osm_max) : osm;
		target  = pid_pkg::w_cnt'(1) << osm_eff;
		cnt_nxt = cnt[sample_chan] + 1'b1;
		sum     = acc[sample_chan] + pid_pkg::w_acc'(sample_data);  // sign extended
		avg     = sum >>> osm_eff;  // divide by sample count
		last    = (cnt_nxt == target);
	end

	////////////////////////////////////////////////////////////
	// counters and accumulators
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk50) begin
		if (reset) begin
			for (int i = 0; i < pid_pkg::n_chan; i++) begin
				acc[i] <= '0;
				cnt[i] <= '0;
			end
			out.valid <= 1'b0;
		end else begin
			out.valid <= sample_valid && last;
			if (sample_valid) begin
				if (last) begin  // block complete, start over
					acc[sample_chan] <= '0;
					cnt[sample_chan] <= '0;
				end else begin
					acc[sample_chan] <= sum;
					cnt[sample_chan] <= cnt_nxt;
				end
			end
		end
	end

	// result, with the channel's lock level at emit time
	always_ff @(posedge clk50) begin
		if (sample_valid && last) begin
			out.data    <= avg[pid_pkg::w_adc-1:0];  // average fits the sample width
			out.chan    <= sample_chan;
			out.lock_en <= lock_en[sample_chan];
		end
	end

endmodule

`default_nettype wire

//--- pid_core.sv
`timescale 1ns/100ps
`default_nettype none

module pid_core (
	input  logic                              clk50,
	input  logic                              reset,
	input  logic signed [pid_pkg::w_coef-1:0] setpoint,
	input  logic signed [pid_pkg::w_coef-1:0] p_coef,
	input  logic signed [pid_pkg::w_coef-1:0] i_coef,
	input  logic signed [pid_pkg::w_coef-1:0] d_coef,
	stage_if.dst                              in,
	stage_if.src                              out
);

	pid_pkg::comp_word_t err_sum  [pid_pkg::n_chan];  // integrator state
	pid_pkg::comp_word_t prev_err [pid_pkg::n_chan];  // for the derivative term

	pid_pkg::comp_word_t err;
	pid_pkg::comp_word_t sum_nxt;
	pid_pkg::comp_word_t diff;
	pid_pkg::comp_word_t pid_sum;

	////////////////////////////////////////////////////////////
	// pid terms
	////////////////////////////////////////////////////////////

	always_comb begin
		err     = pid_pkg::comp_word_t'(setpoint) - pid_pkg::comp_word_t'(in.data);
		sum_nxt = err_sum[in.chan] + err;   // integral includes current error
		diff    = err - prev_err[in.chan];
		pid_sum = pid_pkg::comp_word_t'(p_coef) * err
			+ pid_pkg::comp_word_t'(i_coef) * sum_nxt
			+ pid_pkg::comp_word_t'(d_coef) * diff;
	end

	always_ff @(posedge clk50) begin
		if (reset) begin
			for (int i = 0; i < pid_pkg::n_chan; i++) begin
				err_sum[i]  <= '0;
				prev_err[i] <= '0;
			end
			out.valid <= 1'b0;
		end else begin
			out.valid <= in.valid;
			if (in.valid) begin
				if (in.lock_en) begin
					err_sum[in.chan]  <= sum_nxt;
					prev_err[in.chan] <= err;
				end else begin
					// unlocked sample, forget history
					err_sum[in.chan]  <= '0;
					prev_err[in.chan] <= '0;
				end
			end
		end
	end

	// sum goes out even when unlocked, opp substitutes out_init
	always_ff @(posedge clk50) begin
		if (in.valid) begin
			out.data    <= pid_sum;
			out.chan    <= in.chan;
			out.lock_en <= in.lock_en;
		end
	end

endmodule

`default_nettype wire

//--- output_preprocessor.sv
`timescale 1ns/100ps
`default_nettype none

module output_preprocessor (
	input  logic                      clk50,
	input  logic                      reset,
	input  pid_pkg::dac_code_t        out_max,
	input  pid_pkg::dac_code_t        out_min,
	input  pid_pkg::dac_code_t        out_init,     // code while unlocked, offset while locked
	input  logic [pid_pkg::w_mlt-1:0] multiplier,   // unsigned
	input  logic [pid_pkg::w_rs-1:0]  right_shift,
	stage_if.dst                      in,
	stage_if.src                      out
);

	pid_pkg::comp_word_t scaled;
	pid_pkg::comp_word_t level;
	pid_pkg::dac_code_t  code;

	////////////////////////////////////////////////////////////
	// scale, offset, clamp
	////////////////////////////////////////////////////////////

	always_comb begin
		// multiplier zero extends, product stays signed
		scaled = (in.data * pid_pkg::comp_word_t'(multiplier)) >>> right_shift;
		level  = pid_pkg::comp_word_t'(out_init) + scaled;
		if (!in.lock_en)
			code = out_init;
		else if (level > pid_pkg::comp_word_t'(out_max))
			code = out_max;
		else if (level < pid_pkg::comp_word_t'(out_min))
			code = out_min;
		else
			code = level[pid_pkg::w_dac-1:0];  // in range, so no loss
	end

	always_ff @(posedge clk50) begin
		if (reset)
			out.valid <= 1'b0;
		else
			out.valid <= in.valid;
	end

	always_ff @(posedge clk50) begin
		if (in.valid) begin
			out.data    <= code;
			out.chan    <= in.chan;
			out.lock_en <= in.lock_en;
		end
	end

endmodule

`default_nettype wire

//--- dac_instr_queue.sv
`timescale 1ns/100ps
`default_nettype none

module dac_instr_queue (
	input  logic     clk50,
	input  logic     reset,
	stage_if.dst     in,
	dac_cmd_if.queue cmd
);

	logic [pid_pkg::n_chan-1:0] pending;                  // a code waits for this channel
	pid_pkg::dac_code_t         code_q   [pid_pkg::n_chan];  // newest code per channel
	logic                       busy;                     // frame on the wire

	logic [pid_pkg::n_chan-1:0] pend_now;
	pid_pkg::dac_code_t         code_now [pid_pkg::n_chan];
	pid_pkg::chan_t             sel;
	logic                       idle;

	always_comb begin
		for (int c = 0; c < pid_pkg::n_chan; c++) begin
			// incoming code overwrites the held one, latest wins
			pend_now[c] = pending[c] || (in.valid && in.chan == pid_pkg::chan_t'(c));
			code_now[c] = (in.valid && in.chan == pid_pkg::chan_t'(c)) ? in.data : code_q[c];
		end
		sel = '0;
		for (int c = pid_pkg::n_chan - 1; c >= 0; c--)
			if (pend_now[c])
				sel = pid_pkg::chan_t'(c);  // lowest channel first
		idle = !busy || cmd.done;             // done frees the controller this cycle
	end

	always_ff @(posedge clk50) begin
		if (reset) begin
			pending   <= '0;
			busy      <= 1'b0;
			cmd.valid <= 1'b0;
		end else begin
			cmd.valid <= 1'b0;
			pending   <= pend_now;
			busy      <= busy && !cmd.done;
			if (idle && |pend_now) begin
				cmd.valid     <= 1'b1;
				pending[sel]  <= 1'b0;
				busy          <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk50) begin
		for (int c = 0; c < pid_pkg::n_chan; c++)
			code_q[c] <= code_now[c];
		cmd.chan <= sel;
		cmd.code <= code_now[sel];
	end

endmodule

`default_nettype wire

//--- dac_controller.sv
`timescale 1ns/100ps
`default_nettype none

module dac_controller (
	input  logic    clk50,
	input  logic    reset,
	dac_cmd_if.ctrl cmd,
	output logic    dac_nsync,  // frame select, active low
	output logic    dac_sclk,   // idles low
	output logic    dac_din     // launched on rising sclk
);

	logic                                   busy;
	logic [$clog2(2*pid_pkg::w_frame):0]    half_cnt;  // sclk half periods done
	logic [$clog2(pid_pkg::sclk_div+1)-1:0] div_cnt;
	logic [pid_pkg::w_frame-1:0]            frame;     // shift register, msb first

	logic tick;
	logic start;
	logic last_half;
	logic rise;

	always_comb begin
		tick      = (div_cnt == pid_pkg::sclk_div - 1);
		start     = !busy && cmd.valid;
		last_half = (half_cnt == 2 * pid_pkg::w_frame);
		rise      = busy && tick && !last_half && !dac_sclk;  // next edge raises sclk
	end

	////////////////////////////////////////////////////////////
	// frame sequencing
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk50) begin
		if (reset) begin
			busy      <= 1'b0;
			half_cnt  <= '0;
			div_cnt   <= '0;
			dac_nsync <= 1'b1;
			dac_sclk  <= 1'b0;
			dac_din   <= 1'b0;
			cmd.done  <= 1'b0;
		end else begin
			cmd.done <= 1'b0;
			if (start) begin
				busy      <= 1'b1;
				dac_nsync <= 1'b0;  // sclk still low for one cycle
				half_cnt  <= '0;
				div_cnt   <= '0;
			end else if (busy) begin
				div_cnt <= tick ? '0 : div_cnt + 1'b1;
				if (tick) begin
					if (last_half) begin  // 32 bits out, close the frame
						busy      <= 1'b0;
						dac_nsync <= 1'b1;
						dac_din   <= 1'b0;
						cmd.done  <= 1'b1;
					end else begin
						dac_sclk <= ~dac_sclk;
						half_cnt <= half_cnt + 1'b1;
						if (rise)
							dac_din <= frame[pid_pkg::w_frame-1];
					end
				end
			end
		end
	end

	// prefix, command, address, code, feature bits
	always_ff @(posedge clk50) begin
		if (start)
			frame <= {4'b0000, pid_pkg::dac_cmd_write_update,
				pid_pkg::w_addr'(cmd.chan), cmd.code, 4'b0000};
		else if (rise)
			frame <= frame << 1;
	end

endmodule

`default_nettype wire

//--- pid_top.sv
`timescale 1ns/100ps
`default_nettype none

module pid_top (
	input  logic                              clk50,
	input  logic                              reset,

	// adc samples, already parallel
	input  logic                              sample_valid,
	input  pid_pkg::chan_t                    sample_chan,
	input  pid_pkg::adc_word_t                sample_data,

	// filter and pid settings
	input  logic [pid_pkg::w_osm-1:0]         osm,
	input  logic [pid_pkg::n_chan-1:0]        lock_en,
	input  logic signed [pid_pkg::w_coef-1:0] setpoint,
	input  logic signed [pid_pkg::w_coef-1:0] p_coef,
	input  logic signed [pid_pkg::w_coef-1:0] i_coef,
	input  logic signed [pid_pkg::w_coef-1:0] d_coef,

	// output shaping
	input  pid_pkg::dac_code_t                out_max,
	input  pid_pkg::dac_code_t                out_min,
	input  pid_pkg::dac_code_t                out_init,
	input  logic [pid_pkg::w_mlt-1:0]         multiplier,
	input  logic [pid_pkg::w_rs-1:0]          right_shift,

	// dac8568 pins
	output logic                              dac_nsync,
	output logic                              dac_sclk,
	output logic                              dac_din
);

	////////////////////////////////////////////////////////////
	// stage links
	////////////////////////////////////////////////////////////

	stage_if #(.payload_t(pid_pkg::adc_word_t))  filt_if ();  // averaged samples
	stage_if #(.payload_t(pid_pkg::comp_word_t)) pid_if  ();  // pid sums
	stage_if #(.payload_t(pid_pkg::dac_code_t))  code_if ();  // dac codes
	dac_cmd_if                                   cmd_if  ();

	oversample_filter osf (
		.clk50        (clk50),
		.reset        (reset),
		.osm          (osm),
		.lock_en      (lock_en),
		.sample_valid (sample_valid),
		.sample_chan  (sample_chan),
		.sample_data  (sample_data),
		.out          (filt_if.src)
	);

	pid_core pid (
		.clk50    (clk50),
		.reset    (reset),
		.setpoint (setpoint),
		.p_coef   (p_coef),
		.i_coef   (i_coef),
		.d_coef   (d_coef),
		.in       (filt_if.dst),
		.out      (pid_if.src)
	);

	output_preprocessor opp (
		.clk50       (clk50),
		.reset       (reset),
		.out_max     (out_max),
		.out_min     (out_min),
		.out_init    (out_init),
		.multiplier  (multiplier),
		.right_shift (right_shift),
		.in          (pid_if.dst),
		.out         (code_if.src)
	);

	// channel n goes to dac channel n
	dac_instr_queue dac_iq (
		.clk50 (clk50),
		.reset (reset),
		.in    (code_if.dst),
		.cmd   (cmd_if.queue)
	);

	dac_controller dac_cntrl (
		.clk50     (clk50),
		.reset     (reset),
		.cmd       (cmd_if.ctrl),
		.dac_nsync (dac_nsync),
		.dac_sclk  (dac_sclk),
		.dac_din   (dac_din)
	);

endmodule

`default_nettype wire

//--- pid_top_chk.sv
`timescale 1ns/100ps
`default_nettype none

module pid_top_chk (
	input logic clk50,
	input logic reset,
	input logic dac_nsync,
	input logic dac_sclk,
	input logic cmd_valid  // queue to controller strobe
);

	// no frame may open while held in reset
	nsync_in_reset: assert property (@(posedge clk50) reset && $past(reset) |-> dac_nsync)
		else $error("dac_nsync low during reset");

	// sclk only moves inside a frame
	sclk_framed: assert property (@(posedge clk50) disable iff (reset)
		$changed(dac_sclk) |-> !dac_nsync)
		else $error("dac_sclk toggled with dac_nsync high");

	// controller idle exactly while nsync is high
	start_idle: assert property (@(posedge clk50) disable iff (reset) cmd_valid |-> dac_nsync)
		else $error("dac command issued while a frame was running");

endmodule

bind pid_top pid_top_chk chk_i (
	.clk50     (clk50),
	.reset     (reset),
	.dac_nsync (dac_nsync),
	.dac_sclk  (dac_sclk),
	.cmd_valid (cmd_if.valid)
);

`default_nettype wire

//--- tb_pid_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_pid_top;

	logic                       clk50;
	logic                       reset;
	logic                       sample_valid;
	pid_pkg::chan_t             sample_chan;
	pid_pkg::adc_word_t         sample_data;
	logic [pid_pkg::w_osm-1:0]  osm;
	logic [pid_pkg::n_chan-1:0] lock_en;
	logic signed [15:0]         setpoint;
	logic signed [15:0]         p_coef;
	logic signed [15:0]         i_coef;
	logic signed [15:0]         d_coef;
	pid_pkg::dac_code_t         out_max;
	pid_pkg::dac_code_t         out_min;
	pid_pkg::dac_code_t         out_init;
	logic [pid_pkg::w_mlt-1:0]  multiplier;
	logic [pid_pkg::w_rs-1:0]   right_shift;
	logic                       dac_nsync;
	logic                       dac_sclk;
	logic                       dac_din;

	int          checks;      // value checks done
	int          mismatches;  // wrong values
	int          failures;    // missing or broken frames
	logic [31:0] lfsr;
	longint      err_sum_m  [2];  // model integrator per channel
	longint      prev_err_m [2];  // model previous error

	pid_top pid_top_i (.*);

	initial begin
		clk50 = 1'b0;
		forever #50 clk50 = ~clk50;  // 100 ns period
	end

	////////////////////////////////////////////////////////////
	// random source and reference model
	////////////////////////////////////////////////////////////

	// galois lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			r    = {r[30:0], lfsr[0]};  // one step per bit
			lfsr = lfsr_next(lfsr);
		end
		return r;
	endfunction

	// p*e + i*(sum of e incl. this one) + d*(e - previous e)
	function automatic longint pid_step(input logic ch, input logic signed [17:0] value,
		input logic lock);
		longint err;
		longint sum;
		err = longint'(setpoint) - longint'(value);
		sum = longint'(p_coef) * err + longint'(i_coef) * (err_sum_m[ch] + err)
			+ longint'(d_coef) * (err - prev_err_m[ch]);
		if (lock) begin
			err_sum_m[ch]  += err;
			prev_err_m[ch] = err;
		end else begin  // unlocked sample wipes history
			err_sum_m[ch]  = 0;
			prev_err_m[ch] = 0;
		end
		return sum;
	endfunction

	// offset plus scaled sum, clamped; out_init when unlocked
	function automatic logic [15:0] expected_code(input longint sum, input logic lock);
		longint scaled;
		longint level;
		scaled = (sum * longint'(multiplier)) >>> right_shift;
		level  = longint'(out_init) + scaled;
		if (!lock)
			return out_init;
		if (level > longint'(out_max))
			return out_max;
		if (level < longint'(out_min))
			return out_min;
		return level[15:0];
	endfunction

	function automatic logic [15:0] model_code(input logic ch, input logic signed [17:0] value);
		return expected_code(pid_step(ch, value, lock_en[ch]), lock_en[ch]);
	endfunction

	////////////////////////////////////////////////////////////
	// drive, capture and check helpers
	////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			mismatches++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic set_mode(input logic [2:0] mode, input logic [1:0] lock);
		@(posedge clk50);
		osm     <= mode;
		lock_en <= lock;
	endtask

	task automatic set_pid(input logic signed [15:0] sp, input logic signed [15:0] p,
		input logic signed [15:0] i, input logic signed [15:0] d);
		@(posedge clk50);
		setpoint <= sp;
		p_coef   <= p;
		i_coef   <= i;
		d_coef   <= d;
	endtask

	task automatic set_shaping(input logic [15:0] init, input logic [15:0] lo,
		input logic [15:0] hi, input logic [9:0] mlt, input logic [5:0] rs);
		@(posedge clk50);
		out_init    <= init;
		out_min     <= lo;
		out_max     <= hi;
		multiplier  <= mlt;
		right_shift <= rs;
	endtask

	task automatic send_sample(input logic ch, input logic signed [17:0] value);
		@(posedge clk50);
		sample_valid <= 1'b1;
		sample_chan  <= ch;
		sample_data  <= value;
		@(posedge clk50);
		sample_valid <= 1'b0;  // single cycle strobe
	endtask

	// shift in din at each falling sclk inside nsync low
	task automatic capture_frame(input int limit, output logic found, output logic [31:0] frame);
		int   waited;
		int   nbits;
		logic sclk_prev;
		found  = 1'b0;
		frame  = '0;
		nbits  = 0;
		waited = 0;
		do begin
			@(negedge clk50);
			waited++;
		end while (dac_nsync && waited < limit);
		if (dac_nsync)
			return;  // nothing started
		found     = 1'b1;
		sclk_prev = dac_sclk;
		waited    = 0;
		while (nbits < 32 && waited < 8) begin
			@(negedge clk50);
			waited++;
			if (sclk_prev && !dac_sclk && !dac_nsync) begin
				frame  = {frame[30:0], dac_din};  // msb first
				nbits++;
				waited = 0;
			end
			sclk_prev = dac_sclk;
		end
		assert (nbits == 32) else begin
			failures++;
			$display("frame at %0t stopped after %0d of 32 bits", $time, nbits);
		end
		waited = 0;
		while (!dac_nsync && waited < 8) begin
			@(negedge clk50);
			waited++;
		end
		assert (dac_nsync) else begin
			failures++;
			$display("nsync did not rise after the frame at %0t", $time);
		end
	endtask

	task automatic check_frame(input logic [31:0] frame, input logic ch, input logic [15:0] code);
		check_value("frame prefix", 32'(frame[31:28]), 32'h0);
		check_value("frame command", 32'(frame[27:24]), 32'h3);  // write and update
		check_value("frame address", 32'(frame[23:20]), 32'(ch));
		check_value("dac code", 32'(frame[19:4]), 32'(code));
		check_value("frame feature", 32'(frame[3:0]), 32'h0);
	endtask

	task automatic expect_frame(input logic ch, input logic [15:0] code, output logic [15:0] got);
		logic        found;
		logic [31:0] frame;
		capture_frame(300, found, frame);
		got = frame[19:4];
		assert (found) else begin
			failures++;
			$display("no dac frame started within 300 cycles at %0t", $time);
		end
		if (found)
			check_frame(frame, ch, code);
	endtask

	task automatic expect_no_frame(input int cycles);
		int   n;
		logic quiet;
		quiet = 1'b1;
		for (n = 0; n < cycles && quiet; n++) begin
			@(negedge clk50);
			quiet = dac_nsync;
		end
		assert (quiet) else begin
			failures++;
			$display("unexpected dac frame started at %0t", $time);
		end
	endtask

	////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////

	task automatic test_reset_idle();
		@(negedge clk50);
		check_value("dac_nsync", 32'(dac_nsync), 32'h1);
		check_value("dac_sclk", 32'(dac_sclk), 32'h0);
		expect_no_frame(200);  // no samples, no frames
	endtask

	task automatic test_unlocked_frame();
		logic [15:0] got;
		set_mode(3'd0, 2'b00);
		set_pid(16'sd0, 16'sd1, 16'sd0, 16'sd0);
		set_shaping(16'h1234, 16'h0000, 16'hffff, 10'd1, 6'd0);
		send_sample(1'b1, 18'sd777);
		expect_frame(1'b1, model_code(1'b1, 18'sd777), got);
		check_value("unlocked code", 32'(got), 32'h1234);  // straight out_init
	endtask

	task automatic test_p_scaling();
		logic signed [17:0] vals [4];
		logic [15:0]        got;
		vals = '{18'sd900, 18'sd1201, -18'sd100000, 18'sd100000};
		set_mode(3'd0, 2'b01);
		set_pid(16'sd1000, 16'sd3, 16'sd0, 16'sd0);
		// gain with its top bit set, shift drops fraction bits
		set_shaping(16'h8000, 16'h4000, 16'hc000, 10'd600, 6'd9);
		for (int n = 0; n < 4; n++) begin
			send_sample(1'b0, vals[n]);
			expect_frame(1'b0, model_code(1'b0, vals[n]), got);
			if (n == 2)
				check_value("clamped code", 32'(got), 32'hc000);  // pinned at out_max
			if (n == 3)
				check_value("clamped code", 32'(got), 32'h4000);  // and at out_min
		end
	endtask

	task automatic test_oversample();
		logic signed [17:0] vals [4];
		logic signed [17:0] avg;
		logic [15:0]        got;
		longint             acc;
		vals = '{18'sd100, -18'sd200, 18'sd300, -18'sd203};
		acc  = 0;
		set_mode(3'd2, 2'b01);  // four samples per result
		set_pid(16'sd0, 16'sd1, 16'sd0, 16'sd0);
		set_shaping(16'h8000, 16'h0000, 16'hffff, 10'd1, 6'd0);
		for (int n = 0; n < 3; n++) begin
			send_sample(1'b0, vals[n]);
			acc += longint'(vals[n]);
		end
		expect_no_frame(200);
		send_sample(1'b0, vals[3]);
		acc += longint'(vals[3]);
		avg = 18'(acc >>> 2);  // sum -3 floors to -1
		expect_frame(1'b0, model_code(1'b0, avg), got);
		set_mode(3'd0, 2'b01);
	endtask

	task automatic test_integral();
		logic [15:0] got;
		logic [15:0] first;
		set_mode(3'd0, 2'b00);
		set_pid(16'sd500, 16'sd0, 16'sd2, 16'sd0);
		set_shaping(16'h8000, 16'h0000, 16'hffff, 10'd1, 6'd0);
		send_sample(1'b0, 18'sd400);  // unlocked, clears history
		expect_frame(1'b0, model_code(1'b0, 18'sd400), got);
		set_mode(3'd0, 2'b01);
		first = '0;
		for (int k = 0; k < 3; k++) begin
			send_sample(1'b0, 18'sd400);  // error stays at 100
			expect_frame(1'b0, model_code(1'b0, 18'sd400), got);
			check_value("integral code", 32'(got), 32'(32'h8000 + 200 * (k + 1)));
			if (k == 0)
				first = got;
		end
		set_mode(3'd0, 2'b00);
		send_sample(1'b0, 18'sd400);
		expect_frame(1'b0, model_code(1'b0, 18'sd400), got);
		set_mode(3'd0, 2'b01);
		send_sample(1'b0, 18'sd400);
		expect_frame(1'b0, model_code(1'b0, 18'sd400), got);
		check_value("restarted code", 32'(got), 32'(first));  // single error term again
	endtask

	task automatic test_burst();
		logic [31:0]        frames   [$];
		logic [16:0]        exp_list [$];  // {chan, code} in send order
		int                 pos      [2];
		logic               seen     [2];
		logic [15:0]        last_exp [2];
		logic [15:0]        last_got [2];
		logic               ch;
		logic signed [17:0] value;
		logic               found;
		logic               hit;
		logic [31:0]        frame;
		int                 k;
		set_mode(3'd0, 2'b11);
		set_pid(16'sd0, 16'sd2, 16'sd1, -16'sd1);
		set_shaping(16'h8000, 16'h0000, 16'hffff, 10'd1, 6'd4);
		fork
			for (int n = 0; n < 40; n++) begin
				ch    = (n >= 38) ? n[0] : rand_bits(1) == 32'h1;  // end with ch0, ch1
				value = 18'(rand_bits(18));
				send_sample(ch, value);
				exp_list.push_back({ch, model_code(ch, value)});
			end
			do begin
				capture_frame(200, found, frame);
				if (found)
					frames.push_back(frame);
			end while (found);
		join
		pos  = '{0, 0};
		seen = '{1'b0, 1'b0};
		foreach (frames[f]) begin
			ch = frames[f][20];
			check_value("frame header", 32'({frames[f][31:21], frames[f][3:0]}),
				32'({8'h03, 3'b000, 4'h0}));
			hit = 1'b0;
			for (k = pos[ch]; k < exp_list.size() && !hit; k++)
				if (exp_list[k][16] == ch && exp_list[k][15:0] == frames[f][19:4]) begin
					hit     = 1'b1;
					pos[ch] = k + 1;  // later frames must come after this one
				end
			assert (hit) else begin
				failures++;
				$display("frame %0d on channel %0d carries code %h out of order", f, ch,
					frames[f][19:4]);
			end
			last_got[ch] = frames[f][19:4];
			seen[ch]     = 1'b1;
		end
		foreach (exp_list[e])
			last_exp[exp_list[e][16]] = exp_list[e][15:0];
		for (int c = 0; c < 2; c++) begin
			assert (seen[c]) else begin
				failures++;
				$display("no frame for channel %0d during the burst", c);
			end
			if (seen[c])
				check_value($sformatf("final dac code ch%0d", c), 32'(last_got[c]),
					32'(last_exp[c]));
		end
	endtask

	initial begin
		checks        = 0;
		mismatches    = 0;
		failures      = 0;
		lfsr          = 32'he6892b6f;
		err_sum_m     = '{0, 0};
		prev_err_m    = '{0, 0};
		reset        <= 1'b1;
		sample_valid <= 1'b0;
		sample_chan  <= '0;
		sample_data  <= '0;
		osm          <= '0;
		lock_en      <= '0;
		setpoint     <= '0;
		p_coef       <= '0;
		i_coef       <= '0;
		d_coef       <= '0;
		out_max      <= '1;
		out_min      <= '0;
		out_init     <= '0;
		multiplier   <= '0;
		right_shift  <= '0;
		repeat (16) @(posedge clk50);
		reset <= 1'b0;
		test_reset_idle();
		test_unlocked_frame();
		test_p_scaling();
		test_oversample();
		test_integral();
		test_burst();
		$display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
pid_pkg.sv
stage_if.sv
dac_cmd_if.sv
oversample_filter.sv
pid_core.sv
output_preprocessor.sv
dac_instr_queue.sv
dac_controller.sv
pid_top.sv
pid_top_chk.sv
tb_pid_top.sv

//--- Makefile
TOP = tb_pid_top
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
